// File: logic/perf_defines.svh
`ifndef PERF_DEFINES_SVH
`define PERF_DEFINES_SVH

// data-cache request lanes watched by the monitor
`define DCACHE_NUM_REQS 4

// width of every performance counter
`define PERF_CTR_BITS 44

// cycles between periodic reports unless overridden per instance
`define PERF_REPORT_PERIOD 10000

// enough bits to count 0 .. DCACHE_NUM_REQS lanes
`define LANE_COUNT_BITS $clog2(`DCACHE_NUM_REQS + 1)

// per-cycle change of the dcache outstanding reads with one extra sign bit
`define LANE_DELTA_BITS (`LANE_COUNT_BITS + 1)

// per-cycle change of the icache outstanding reads from -1 to +1
`define IFETCH_DELTA_BITS 2

`endif

// File: logic/perf_pkg.sv
`include "perf_defines.svh"

package perf_pkg;

    // handshake strobes of one instruction-cache port
    typedef struct packed {
        logic req_valid;
        logic req_ready;
        logic rsp_valid;
        logic rsp_ready;
    } icache_strobes_t;

    // data-cache lanes with one bit per lane in each vector
    typedef struct packed {
        logic [`DCACHE_NUM_REQS-1:0] req_valid;
        logic [`DCACHE_NUM_REQS-1:0] req_ready;
        logic [`DCACHE_NUM_REQS-1:0] req_rw;
        logic [`DCACHE_NUM_REQS-1:0] rsp_valid;
        logic [`DCACHE_NUM_REQS-1:0] rsp_ready;
    } dcache_strobes_t;

    typedef logic [`LANE_COUNT_BITS-1:0] lane_count_t;

    // events seen in a single cycle
    typedef struct packed {
        logic        ifetch_req;
        logic        ifetch_rsp;
        lane_count_t load_reqs;
        lane_count_t store_reqs;
        lane_count_t load_rsps;
    } mem_events_t;

    typedef struct packed {
        logic [`PERF_CTR_BITS-1:0] ifetches;
        logic [`PERF_CTR_BITS-1:0] loads;
        logic [`PERF_CTR_BITS-1:0] stores;
        logic [`PERF_CTR_BITS-1:0] icache_pending;
        logic [`PERF_CTR_BITS-1:0] dcache_pending;
        logic [`PERF_CTR_BITS-1:0] ifetch_latency;
        logic [`PERF_CTR_BITS-1:0] load_latency;
    } perf_counters_t;

endpackage

// File: logic/mem_event_decode.sv
`timescale 1ns/1ps

`include "perf_defines.svh"

module mem_event_decode (
    input  logic                      clk,
    input  logic                      reset,
    input  perf_pkg::icache_strobes_t icache,
    input  perf_pkg::dcache_strobes_t dcache,
    output perf_pkg::mem_events_t     events
);

    // per-lane fires before and after the one-cycle delay
    logic [`DCACHE_NUM_REQS-1:0] rd_req_fire;
    logic [`DCACHE_NUM_REQS-1:0] wr_req_fire;
    logic [`DCACHE_NUM_REQS-1:0] rd_req_fire_r;
    logic [`DCACHE_NUM_REQS-1:0] wr_req_fire_r;
    logic [`DCACHE_NUM_REQS-1:0] rsp_fire;

    logic icache_req_fire;
    logic icache_rsp_fire;

    // number of set bits across the lanes
    function automatic perf_pkg::lane_count_t pop_count(
        input logic [`DCACHE_NUM_REQS-1:0] lanes
    );
        perf_pkg::lane_count_t count;
        count = '0;
        for (int i = 0; i < `DCACHE_NUM_REQS; i++) begin
            count = count + perf_pkg::lane_count_t'(lanes[i]);
        end
        return count;
    endfunction

    assign icache_req_fire = icache.req_valid && icache.req_ready;
    assign icache_rsp_fire = icache.rsp_valid && icache.rsp_ready;

    // rw set marks a store, clear marks a load
    always_comb begin
        for (int i = 0; i < `DCACHE_NUM_REQS; i++) begin
            rd_req_fire[i] = dcache.req_valid[i] && dcache.req_ready[i] && !dcache.req_rw[i];
            wr_req_fire[i] = dcache.req_valid[i] && dcache.req_ready[i] && dcache.req_rw[i];
            rsp_fire[i]    = dcache.rsp_valid[i] && dcache.rsp_ready[i];
        end
    end

    // request fires are delayed one cycle before they are counted
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_req_fire_r <= '0;
            wr_req_fire_r <= '0;
        end else begin
            rd_req_fire_r <= rd_req_fire;
            wr_req_fire_r <= wr_req_fire;
        end
    end

    // responses and ifetch stay in the same cycle
    always_comb begin
        events.ifetch_req = icache_req_fire;
        events.ifetch_rsp = icache_rsp_fire;
        events.load_reqs  = pop_count(rd_req_fire_r);
        events.store_reqs = pop_count(wr_req_fire_r);
        events.load_rsps  = pop_count(rsp_fire);
    end

endmodule

// File: logic/perf_accumulate.sv
`timescale 1ns/1ps

`include "perf_defines.svh"

module perf_accumulate (
    input  logic                     clk,
    input  logic                     reset,
    input  perf_pkg::mem_events_t    events,
    output perf_pkg::perf_counters_t counters
);

    // per-cycle change of outstanding reads
    logic signed [`IFETCH_DELTA_BITS-1:0] icache_delta;
    logic signed [`LANE_DELTA_BITS-1:0]   dcache_delta;

    // sign-extended to the counter width
    logic [`PERF_CTR_BITS-1:0] icache_step;
    logic [`PERF_CTR_BITS-1:0] dcache_step;

    logic [`PERF_CTR_BITS-1:0] ifetches;
    logic [`PERF_CTR_BITS-1:0] loads;
    logic [`PERF_CTR_BITS-1:0] stores;
    logic [`PERF_CTR_BITS-1:0] icache_pending;
    logic [`PERF_CTR_BITS-1:0] dcache_pending;
    logic [`PERF_CTR_BITS-1:0] ifetch_latency;
    logic [`PERF_CTR_BITS-1:0] load_latency;

    // request minus response after zero extension so the difference keeps its sign
    assign icache_delta = $signed({1'b0, events.ifetch_req})
                        - $signed({1'b0, events.ifetch_rsp});
    assign dcache_delta = $signed({1'b0, events.load_reqs})
                        - $signed({1'b0, events.load_rsps});

    assign icache_step = `PERF_CTR_BITS'(icache_delta);
    assign dcache_step = `PERF_CTR_BITS'(dcache_delta);

    // outstanding reads may go negative and wrap
    always_ff @(posedge clk) begin
        if (reset) begin
            icache_pending <= '0;
            dcache_pending <= '0;
        end else begin
            icache_pending <= icache_pending + icache_step;
            dcache_pending <= dcache_pending + dcache_step;
        end
    end

    // event totals
    always_ff @(posedge clk) begin
        if (reset) begin
            ifetches <= '0;
            loads    <= '0;
            stores   <= '0;
        end else begin
            ifetches <= ifetches + `PERF_CTR_BITS'(events.ifetch_req);
            loads    <= loads + `PERF_CTR_BITS'(events.load_reqs);
            stores   <= stores + `PERF_CTR_BITS'(events.store_reqs);
        end
    end

    // latency sums the pending values as they were before this edge
    always_ff @(posedge clk) begin
        if (reset) begin
            ifetch_latency <= '0;
            load_latency   <= '0;
        end else begin
            ifetch_latency <= ifetch_latency + icache_pending;
            load_latency   <= load_latency + dcache_pending;
        end
    end

    always_comb begin
        counters.ifetches       = ifetches;
        counters.loads          = loads;
        counters.stores         = stores;
        counters.icache_pending = icache_pending;
        counters.dcache_pending = dcache_pending;
        counters.ifetch_latency = ifetch_latency;
        counters.load_latency   = load_latency;
    end

endmodule

// File: logic/perf_report.sv
`timescale 1ns/1ps

`include "perf_defines.svh"

module perf_report #(
    parameter int unsigned report_period = `PERF_REPORT_PERIOD
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     busy,
    input  perf_pkg::perf_counters_t counters,
    output logic                     report,
    output perf_pkg::perf_counters_t snapshot
);

    // period counter runs 0 .. report_period inclusive
    localparam int count_bits = $clog2(report_period + 1);

    logic                  busy_prev;
    logic [count_bits-1:0] period_count;
    logic                  busy_fall;
    logic                  period_hit;
    logic                  trigger;

    assign busy_fall  = busy_prev && !busy;
    assign period_hit = (period_count == '0);
    assign trigger    = busy_fall || period_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_prev <= 1'b0;
        end else begin
            busy_prev <= busy;
        end
    end

    // wraps back to zero after reaching the period
    always_ff @(posedge clk) begin
        if (reset) begin
            period_count <= '0;
        end else if (period_count == count_bits'(report_period)) begin
            period_count <= '0;
        end else begin
            period_count <= period_count + 1'b1;
        end
    end

    // pulse lands one cycle after the trigger
    always_ff @(posedge clk) begin
        if (reset) begin
            report <= 1'b0;
        end else begin
            report <= trigger;
        end
    end

    // counters of the trigger cycle held until the next trigger
    always_ff @(posedge clk) begin
        if (reset) begin
            snapshot <= '0;
        end else if (trigger) begin
            snapshot <= counters;
        end
    end

endmodule

// File: logic/core_perf_monitor.sv
`timescale 1ns/1ps

`include "perf_defines.svh"

module core_perf_monitor #(
    parameter int unsigned report_period = `PERF_REPORT_PERIOD
) (
    input  logic                      clk,
    input  logic                      reset,
    input  perf_pkg::icache_strobes_t icache,
    input  perf_pkg::dcache_strobes_t dcache,
    input  logic                      busy,
    output perf_pkg::perf_counters_t  counters,
    output logic                      report,
    output perf_pkg::perf_counters_t  snapshot
);

    perf_pkg::mem_events_t events;

    // bus strobes to per-cycle event counts
    mem_event_decode u_decode (
        .clk    (clk),
        .reset  (reset),
        .icache (icache),
        .dcache (dcache),
        .events (events)
    );

    // running totals and latency sums
    perf_accumulate u_accumulate (
        .clk      (clk),
        .reset    (reset),
        .events   (events),
        .counters (counters)
    );

    // report on busy falling or period wrap
    perf_report #(
        .report_period (report_period)
    ) u_report (
        .clk      (clk),
        .reset    (reset),
        .busy     (busy),
        .counters (counters),
        .report   (report),
        .snapshot (snapshot)
    );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 20
) (
    output logic clk
);

    // free running clock that starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

// File: sim/core_perf_monitor_asserts.sv
`timescale 1ns/1ps

module core_perf_monitor_asserts (
    input logic                     clk,
    input logic                     reset,
    input logic                     busy,
    input logic                     report,
    input perf_pkg::perf_counters_t counters
);

    // one trigger gives one pulse
    report_single_cycle: assert property (
        @(posedge clk) disable iff (reset) report |=> !report
    ) else $error("report stayed high for two cycles in a row");

    // busy dropping must be reported on the next cycle
    report_after_busy_fall: assert property (
        @(posedge clk) disable iff (reset) $fell(busy) |=> report
    ) else $error("no report in the cycle after busy fell");

    counters_clear_after_reset: assert property (
        @(posedge clk) reset |=> (counters == '0)
    ) else $error("counters not zero in the cycle after reset");

endmodule

bind core_perf_monitor core_perf_monitor_asserts u_asserts (
    .clk      (clk),
    .reset    (reset),
    .busy     (busy),
    .report   (report),
    .counters (counters)
);

// File: sim/core_perf_monitor_tb.sv
`timescale 1ns/1ps

`include "perf_defines.svh"

module core_perf_monitor_tb;

    typedef logic [`PERF_CTR_BITS-1:0] ctr_t;

    localparam int unsigned report_period = 50;
    localparam int random_cycles = 600;
    localparam int report_timeout = 2 * report_period + 4;

    logic                      clk;
    logic                      reset;
    perf_pkg::icache_strobes_t icache;
    perf_pkg::dcache_strobes_t dcache;
    logic                      busy;
    perf_pkg::perf_counters_t  counters;
    logic                      report;
    perf_pkg::perf_counters_t  snapshot;

    // model state advanced once per clock
    logic [`DCACHE_NUM_REQS-1:0] m_rd_fire_r;
    logic [`DCACHE_NUM_REQS-1:0] m_wr_fire_r;
    perf_pkg::perf_counters_t    m_ctr;
    perf_pkg::perf_counters_t    m_snapshot;
    logic                        m_report;
    logic                        m_busy_prev;
    int unsigned                 m_period;

    logic [31:0] rng_state;

    tb_clock #(.period_ns(20)) u_clock (.clk(clk));

    core_perf_monitor #(
        .report_period (report_period)
    ) UUT (
        .clk      (clk),
        .reset    (reset),
        .icache   (icache),
        .dcache   (dcache),
        .busy     (busy),
        .counters (counters),
        .report   (report),
        .snapshot (snapshot)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic ctr_t count_ones(input logic [`DCACHE_NUM_REQS-1:0] lanes);
        ctr_t n;
        n = '0;
        for (int i = 0; i < `DCACHE_NUM_REQS; i++) begin
            n = n + ctr_t'(lanes[i]);
        end
        return n;
    endfunction

    // a busy fall right next to a period wrap would give back to back reports
    function automatic logic spaced_busy(input logic want);
        if (m_busy_prev && !want && (m_period == 1 || m_period == report_period)) begin
            return 1'b1;
        end
        return want;
    endfunction

    task automatic stop_with_failure();
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input ctr_t got, input ctr_t exp);
        assert (got === exp)
        else begin
            $display("ERROR at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_counters(input string prefix, input perf_pkg::perf_counters_t got,
                                  input perf_pkg::perf_counters_t exp);
        check_value({prefix, ".ifetches"}, got.ifetches, exp.ifetches);
        check_value({prefix, ".loads"}, got.loads, exp.loads);
        check_value({prefix, ".stores"}, got.stores, exp.stores);
        check_value({prefix, ".icache_pending"}, got.icache_pending, exp.icache_pending);
        check_value({prefix, ".dcache_pending"}, got.dcache_pending, exp.dcache_pending);
        check_value({prefix, ".ifetch_latency"}, got.ifetch_latency, exp.ifetch_latency);
        check_value({prefix, ".load_latency"}, got.load_latency, exp.load_latency);
    endtask

    task automatic compare_all();
        check_value("report", ctr_t'(report), ctr_t'(m_report));
        check_counters("counters", counters, m_ctr);
        check_counters("snapshot", snapshot, m_snapshot);
    endtask

    task automatic drive_random();
        logic [31:0]               r;
        logic                      want;
        perf_pkg::dcache_strobes_t d;
        r = next_rand();
        icache = perf_pkg::icache_strobes_t'(r[31:28]);
        want = busy;
        // busy toggles about one cycle in eight
        if (r[27:25] == 3'd0) begin
            want = !busy;
        end
        for (int i = 0; i < `DCACHE_NUM_REQS; i++) begin
            r = next_rand();
            d.req_valid[i] = r[31];
            d.req_ready[i] = r[30];
            d.req_rw[i]    = r[29];
            d.rsp_valid[i] = r[28];
            d.rsp_ready[i] = r[27];
        end
        dcache = d;
        busy = spaced_busy(want);
    endtask

    task automatic drive_idle();
        icache = '0;
        dcache = '0;
        busy = spaced_busy(1'b0);
    endtask

    // DUT state after the next rising edge for the inputs now driven
    task automatic model_step();
        logic [`DCACHE_NUM_REQS-1:0] rd_fire;
        logic [`DCACHE_NUM_REQS-1:0] wr_fire;
        logic [`DCACHE_NUM_REQS-1:0] rsp_fire;
        ctr_t                        ifetch_req;
        ctr_t                        ifetch_rsp;
        ctr_t                        load_reqs;
        ctr_t                        store_reqs;
        ctr_t                        load_rsps;
        logic                        trigger;
        ifetch_req = ctr_t'(icache.req_valid && icache.req_ready);
        ifetch_rsp = ctr_t'(icache.rsp_valid && icache.rsp_ready);
        for (int i = 0; i < `DCACHE_NUM_REQS; i++) begin
            rd_fire[i]  = dcache.req_valid[i] && dcache.req_ready[i] && !dcache.req_rw[i];
            wr_fire[i]  = dcache.req_valid[i] && dcache.req_ready[i] && dcache.req_rw[i];
            rsp_fire[i] = dcache.rsp_valid[i] && dcache.rsp_ready[i];
        end
        // dcache requests counted now fired one cycle earlier
        load_reqs  = count_ones(m_rd_fire_r);
        store_reqs = count_ones(m_wr_fire_r);
        load_rsps  = count_ones(rsp_fire);
        trigger = (m_busy_prev && !busy) || (m_period == 0);
        if (trigger) begin
            m_snapshot = m_ctr;
        end
        m_report = trigger;
        // latency uses pending before this update
        m_ctr.ifetch_latency = m_ctr.ifetch_latency + m_ctr.icache_pending;
        m_ctr.load_latency   = m_ctr.load_latency + m_ctr.dcache_pending;
        m_ctr.ifetches       = m_ctr.ifetches + ifetch_req;
        m_ctr.loads          = m_ctr.loads + load_reqs;
        m_ctr.stores         = m_ctr.stores + store_reqs;
        m_ctr.icache_pending = m_ctr.icache_pending + ifetch_req - ifetch_rsp;
        m_ctr.dcache_pending = m_ctr.dcache_pending + load_reqs - load_rsps;
        m_rd_fire_r = rd_fire;
        m_wr_fire_r = wr_fire;
        m_busy_prev = busy;
        if (m_period == report_period) begin
            m_period = 0;
        end else begin
            m_period = m_period + 1;
        end
    endtask

    // check outputs once per clock and drive the next inputs
    task automatic advance(input logic random_inputs);
        @(negedge clk);
        compare_all();
        if (random_inputs) begin
            drive_random();
        end else begin
            drive_idle();
        end
        model_step();
    endtask

    task automatic wait_for_report(output int cycles);
        cycles = 0;
        do begin
            advance(1'b0);
            cycles++;
        end while (!report && cycles < report_timeout);
        if (!report) begin
            $display("timeout: no report pulse within %0d cycles", report_timeout);
            stop_with_failure();
        end
    endtask

    initial begin
        perf_pkg::perf_counters_t held;
        int                       gap;
        reset = 1'b1;
        icache = '0;
        dcache = '0;
        busy = 1'b0;
        rng_state = 32'h8d73633b;
        m_rd_fire_r = '0;
        m_wr_fire_r = '0;
        m_ctr = '0;
        m_snapshot = '0;
        m_report = 1'b0;
        m_busy_prev = 1'b0;
        m_period = 0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // nothing driven yet
        check_value("report", ctr_t'(report), '0);
        check_counters("counters", counters, '0);
        check_counters("snapshot", snapshot, '0);
        model_step();

        for (int c = 0; c < random_cycles; c++) begin
            advance(1'b1);
        end

        // quiet bus and busy low leave only periodic reports
        repeat (4) advance(1'b0);
        held = m_ctr;
        wait_for_report(gap);
        wait_for_report(gap);
        check_value("report spacing in cycles", ctr_t'(gap), ctr_t'(report_period + 1));
        check_value("counters.ifetches", counters.ifetches, held.ifetches);
        check_value("counters.loads", counters.loads, held.loads);
        check_value("counters.stores", counters.stores, held.stores);
        check_value("counters.icache_pending", counters.icache_pending, held.icache_pending);
        check_value("counters.dcache_pending", counters.dcache_pending, held.dcache_pending);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: compile.f
+incdir+logic
logic/perf_pkg.sv
logic/mem_event_decode.sv
logic/perf_accumulate.sv
logic/perf_report.sv
logic/core_perf_monitor.sv
sim/tb_clock.sv
sim/core_perf_monitor_asserts.sv
sim/core_perf_monitor_tb.sv

// File: Makefile
TOP = core_perf_monitor_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

obj_dir/V$(TOP): compile.f $(wildcard logic/*.sv logic/*.svh sim/*.sv)
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "=== PASS ===" sim.log; then echo "simulation ended early"; exit 1; fi
	@echo "simulation finished cleanly"

clean:
	rm -rf obj_dir sim.log
